// File: vlog.f
logic/ptw_pkg.sv
logic/ptw_pte_check.sv
logic/ptw_addr_gen.sv
logic/ptw_walk_ctx.sv
logic/ptw_ctrl.sv
logic/ptw_top.sv
testbench/ptw_checker.sv
testbench/tb_ptw.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ptw
FILELIST = vlog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_ptw.sv
// Testbench for the Sv39 page table walker with table memory, read responder and reference model
`timescale 1ns/1ps
`default_nettype none

module tb_ptw import ptw_pkg::*; ();

    localparam int MAX_DLY    = 4;
    localparam int N_TESTS    = 18;
    // Worst case cycles of one level with request and response both delayed
    localparam int LVL_CYC    = 2 * MAX_DLY + 4;
    // Start level held over two walks
    localparam int HOLD_CYC   = 6 * LVL_CYC;
    localparam int TEST_CYC   = 3 * LVL_CYC + HOLD_CYC + 6;
    localparam int TIMEOUT_NS = 2 * N_TESTS * TEST_CYC * 8;

    // Root table followed by the level 2 and level 3 tables
    localparam logic [PPN_W-1:0] ROOT     = 44'h100;
    localparam logic [PPN_W-1:0] T2       = 44'h200;
    localparam logic [PPN_W-1:0] T3       = 44'h300;
    localparam logic [PPN_W-1:0] LEAF_PPN = 44'h4567;
    localparam logic [PPN_W-1:0] PPN_2M   = 44'h1200;
    localparam logic [PPN_W-1:0] PPN_1G   = 44'h40000;
    localparam logic [VA_W-1:0]  IOVA     = {9'd1, 9'd2, 9'd3, 12'habc};

    // Flag bytes ordered d a g u x w r v
    localparam logic [7:0] F_PTR  = 8'h01;
    localparam logic [7:0] F_LEAF = 8'hc7;
    localparam logic [7:0] F_G    = 8'h20;
    localparam logic [7:0] F_A    = 8'h40;
    localparam logic [7:0] F_D    = 8'h80;

    logic         clk_i;
    logic         rst_ni;
    logic         init_ptw_i;
    walk_req_t    req;
    logic [PPN_W-1:0] root_ppn;
    mem_rsp_t     mem_rsp;
    mem_req_t     mem_req;
    logic         ptw_active;
    logic         update;
    iotlb_up_t    up;
    logic         ptw_error;
    cause_e       cause;
    logic         exp_valid;
    logic         exp_err;
    cause_e       exp_cause;
    iotlb_up_t    exp_up;
    logic [127:0] exp_tag;
    logic         report;
    int           n_ends;
    int           n_bad;

    // Sparse table memory and addresses that answer with a bus error
    pte_t mem [logic [PA_W-1:0]];
    bit   bad [logic [PA_W-1:0]];

    ptw_top uut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .init_ptw_i   (init_ptw_i),
        .req_i        (req),
        .root_ppn_i   (root_ppn),
        .mem_rsp_i    (mem_rsp),
        .mem_req_o    (mem_req),
        .ptw_active_o (ptw_active),
        .update_o     (update),
        .up_o         (up),
        .ptw_error_o  (ptw_error),
        .cause_o      (cause)
    );

    ptw_checker ptw_checker (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .exp_valid_i  (exp_valid),
        .exp_err_i    (exp_err),
        .exp_cause_i  (exp_cause),
        .exp_up_i     (exp_up),
        .exp_tag_i    (exp_tag),
        .report_i     (report),
        .update_i     (update),
        .up_i         (up),
        .ptw_error_i  (ptw_error),
        .cause_i      (cause),
        .ptw_active_i (ptw_active),
        .r_valid_i    (mem_rsp.r_valid),
        .r_ready_i    (mem_req.r_ready),
        .n_ends_o     (n_ends),
        .n_bad_o      (n_bad)
    );

    function automatic pte_t make_pte(input logic [PPN_W-1:0] ppn, input logic [7:0] flags);
        return pte_t'({10'h0, ppn, 2'b00, flags});
    endfunction

    function automatic logic [PA_W-1:0] entry_addr(input logic [PPN_W-1:0] ppn,
                                                   input logic [8:0] idx);
        return {ppn, idx, 3'b000};
    endfunction

    // Sv39 walk over the table memory where level 0 maps 1G and level 2 maps 4K
    function automatic void walk_ref(input walk_req_t r, input logic [PPN_W-1:0] root,
                                     output logic is_err, output cause_e c,
                                     output iotlb_up_t u);
        logic [PPN_W-1:0] ppn;
        logic [PA_W-1:0]  a;
        pte_t             pte;
        logic             glob;
        logic             fault;
        logic             done;
        int               lvl;
        ppn    = root;
        glob   = 1'b0;
        done   = 1'b0;
        is_err = 1'b0;
        c      = LOAD_PAGE_FAULT;
        u      = '0;
        for (lvl = 0; (lvl < 3) && !done; lvl++) begin
            a     = entry_addr(ppn, r.iova[38 - 9 * lvl -: 9]);
            pte   = mem.exists(a) ? mem[a] : '0;
            fault = !pte.v || (pte.w && !pte.r) || (pte.reserved != 0);
            if (bad.exists(a) != 0) begin
                is_err = 1'b1;
                c      = PT_DATA_CORRUPTION;
                done   = 1'b1;
            end else begin
                if (!fault && !pte.r && !pte.x) begin
                    // Pointer entries have A D U reserved and none is allowed at 4K
                    if (pte.a || pte.d || pte.u || (lvl == 2)) begin
                        fault = 1'b1;
                    end else begin
                        glob = glob | pte.g;
                        ppn  = pte.ppn;
                    end
                end else if (!fault) begin
                    fault = !pte.a || !pte.r || (r.is_store && !pte.d)
                         || ((lvl == 0) && (pte.ppn[17:0] != 0))
                         || ((lvl == 1) && (pte.ppn[8:0] != 0));
                    if (!fault) begin
                        u.vpn       = r.iova[38:12];
                        u.pscid     = r.pscid;
                        u.is_1g     = (lvl == 0);
                        u.is_2m     = (lvl == 1);
                        u.content   = pte;
                        u.content.g = pte.g | glob;
                        done        = 1'b1;
                    end
                end
                if (fault) begin
                    is_err = 1'b1;
                    c      = r.is_store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
                    done   = 1'b1;
                end
            end
        end
    endfunction

    // Runs one walk with tables rebuilt from the three entries on the path
    task automatic walk(input logic [127:0] tag, input pte_t e1, input pte_t e2,
                        input pte_t e3, input logic is_store, input int bad_lvl,
                        input int hold);
        walk_req_t r;
        logic      err;
        cause_e    c;
        iotlb_up_t u;
        int        target;
        target     = n_ends + 1;
        r.iova     = IOVA;
        r.pscid    = PSCID_W'(32'h5a000 + target);
        r.is_store = is_store;
        mem.delete();
        bad.delete();
        mem[entry_addr(ROOT, IOVA[38:30])] = e1;
        mem[entry_addr(T2, IOVA[29:21])]   = e2;
        mem[entry_addr(T3, IOVA[20:12])]   = e3;
        case (bad_lvl)
            1: bad[entry_addr(ROOT, IOVA[38:30])] = 1'b1;
            2: bad[entry_addr(T2, IOVA[29:21])]   = 1'b1;
            3: bad[entry_addr(T3, IOVA[20:12])]   = 1'b1;
            default: ;
        endcase
        walk_ref(r, ROOT, err, c, u);
        @(posedge clk_i);
        req        <= r;
        exp_valid  <= 1'b1;
        exp_err    <= err;
        exp_cause  <= c;
        exp_up     <= u;
        exp_tag    <= tag;
        init_ptw_i <= 1'b1;
        @(posedge clk_i);
        exp_valid <= 1'b0;
        if (hold == 0) begin
            init_ptw_i <= 1'b0;
        end
        // Checker count moves at the walk end or its per-walk timeout
        while (n_ends < target) begin
            @(posedge clk_i);
        end
        repeat (hold) @(posedge clk_i);
        init_ptw_i <= 1'b0;
        repeat (3) @(posedge clk_i);
    endtask

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Read slave with a random wait before ar_ready and before r_valid
    initial begin : responder
        logic [PA_W-1:0] addr;
        int              dly;
        void'($urandom(43539));
        mem_rsp <= '0;
        forever begin
            @(posedge clk_i);
            if (mem_req.ar_valid) begin
                addr = mem_req.ar_addr;
                dly  = int'($urandom % (MAX_DLY + 1));
                repeat (dly) @(posedge clk_i);
                mem_rsp.ar_ready <= 1'b1;
                @(posedge clk_i);
                mem_rsp.ar_ready <= 1'b0;
                dly = int'($urandom % (MAX_DLY + 1));
                repeat (dly) @(posedge clk_i);
                mem_rsp.r_valid <= 1'b1;
                mem_rsp.r_data  <= mem.exists(addr) ? mem[addr] : '0;
                mem_rsp.r_err   <= (bad.exists(addr) != 0);
                // A single beat that the walker takes in this cycle
                @(posedge clk_i);
                mem_rsp.r_valid <= 1'b0;
                mem_rsp.r_err   <= 1'b0;
            end
        end
    end

    initial begin : main
        pte_t p1;
        pte_t p2;
        pte_t lf;
        pte_t rs;
        rst_ni     <= 1'b0;
        init_ptw_i <= 1'b0;
        req        <= '0;
        root_ppn   <= ROOT;
        exp_valid  <= 1'b0;
        exp_err    <= 1'b0;
        exp_cause  <= LOAD_PAGE_FAULT;
        exp_up     <= '0;
        exp_tag    <= '0;
        report     <= 1'b0;
        p1 = make_pte(T2, F_PTR);
        p2 = make_pte(T3, F_PTR);
        lf = make_pte(LEAF_PPN, F_LEAF);
        rs = lf;
        rs.reserved = 10'h200;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);
        walk("4k load", p1, p2, lf, 1'b0, 0, 0);
        walk("4k store", p1, p2, lf, 1'b1, 0, 0);
        walk("2m leaf", p1, make_pte(PPN_2M, F_LEAF), '0, 1'b0, 0, 0);
        walk("1g leaf", make_pte(PPN_1G, F_LEAF), '0, '0, 1'b1, 0, 0);
        walk("2m misaligned", p1, make_pte(PPN_2M + 44'h1, F_LEAF), '0, 1'b1, 0, 0);
        walk("1g misaligned", make_pte(PPN_1G + 44'h200, F_LEAF), '0, '0, 1'b0, 0, 0);
        walk("global ptr", make_pte(T2, F_PTR | F_G), p2, lf, 1'b0, 0, 0);
        walk("v clear", p1, p2, make_pte(LEAF_PPN, F_LEAF & ~F_PTR), 1'b0, 0, 0);
        walk("w without r", p1, p2, make_pte(LEAF_PPN, 8'hc5), 1'b1, 0, 0);
        walk("reserved", p1, p2, rs, 1'b0, 0, 0);
        walk("a clear", p1, p2, make_pte(LEAF_PPN, F_LEAF & ~F_A), 1'b0, 0, 0);
        walk("d clear store", p1, p2, make_pte(LEAF_PPN, F_LEAF & ~F_D), 1'b1, 0, 0);
        walk("ptr with a", p1, make_pte(T3, F_PTR | F_A), lf, 1'b1, 0, 0);
        walk("ptr at lvl3", p1, p2, make_pte(LEAF_PPN, F_PTR), 1'b0, 0, 0);
        walk("bus err lvl1", p1, p2, lf, 1'b0, 1, 0);
        walk("bus err lvl2", p1, p2, lf, 1'b1, 2, 0);
        walk("bus err lvl3", p1, p2, lf, 1'b0, 3, 0);
        // A second walk under the held level would show up as a stray end
        walk("init held", p1, p2, lf, 1'b0, 0, HOLD_CYC);
        repeat (4) @(posedge clk_i);
        report <= 1'b1;
        @(posedge clk_i);
        report <= 1'b0;
        @(posedge clk_i);
        if ((n_bad == 0) && (n_ends == N_TESTS)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, walker or responder stuck", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/ptw_checker.sv
// Result checker that compares each walker end with its expected record
`timescale 1ns/1ps
`default_nettype none

module ptw_checker import ptw_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         exp_valid_i,
    input  logic         exp_err_i,
    input  cause_e       exp_cause_i,
    input  iotlb_up_t    exp_up_i,
    input  logic [127:0] exp_tag_i,
    input  logic         report_i,
    input  logic         update_i,
    input  iotlb_up_t    up_i,
    input  logic         ptw_error_i,
    input  cause_e       cause_i,
    input  logic         ptw_active_i,
    input  logic         r_valid_i,
    input  logic         r_ready_i,
    output int           n_ends_o,
    output int           n_bad_o
);

    // Far above three levels with the longest responder delays
    localparam int WALK_LIMIT = 200;

    // Expected records in arrival order
    logic         err_fifo[$];
    cause_e       cause_fifo[$];
    iotlb_up_t    up_fifo[$];
    logic [127:0] tag_fifo[$];
    int           wait_cnt = 0;
    int           n_ends = 0;
    int           n_bad = 0;
    int           n_stray = 0;
    logic         pending;
    logic         stray_seen = 1'b0;

    task automatic close_walk();
        logic         e;
        cause_e       c;
        iotlb_up_t    u;
        logic [127:0] t;
        logic         ok;
        e  = err_fifo.pop_front();
        c  = cause_fifo.pop_front();
        u  = up_fifo.pop_front();
        t  = tag_fifo.pop_front();
        ok = 1'b1;
        // Update where a fault was due or the reverse
        if (update_i == e) begin
            $display("Error update_o (%0s): expected 0x%h, got 0x%h", t, !e, update_i);
            ok = 1'b0;
        end else if (e && (cause_i != c)) begin
            $display("Error cause_o (%0s): expected 0x%h, got 0x%h", t, c, cause_i);
            ok = 1'b0;
        end else if (!e && (up_i != u)) begin
            $display("Error up_o (%0s): expected 0x%h, got 0x%h", t, u, up_i);
            ok = 1'b0;
        end
        $display("%0s: %s", t, ok ? "ok" : "mismatch");
        n_ends++;
        if (!ok) begin
            n_bad++;
        end
        wait_cnt = 0;
    endtask

    always @(posedge clk_i) begin
        pending = (tag_fifo.size() != 0);
        if (rst_ni) begin
            if (update_i || ptw_error_i) begin
                if (!pending) begin
                    $display("Walk ended while no request was pending");
                    n_stray++;
                end else begin
                    close_walk();
                end
            end else if (pending) begin
                wait_cnt++;
                // Walk never reached an update or an error
                if (wait_cnt > WALK_LIMIT) begin
                    $display("%0s: walk did not end within %0d cycles", tag_fifo[0],
                             WALK_LIMIT);
                    void'(err_fifo.pop_front());
                    void'(cause_fifo.pop_front());
                    void'(up_fifo.pop_front());
                    void'(tag_fifo.pop_front());
                    n_ends++;
                    n_bad++;
                    wait_cnt = 0;
                end
            end
            // Walker must stay idle between walks
            // One report per idle stretch
            if (!pending && ptw_active_i && !stray_seen) begin
                $display("Walker became active with no walk requested");
                n_stray++;
                stray_seen = 1'b1;
            end else if (pending) begin
                stray_seen = 1'b0;
            end
            // A response beat is taken in the cycle it is offered
            if (r_ready_i != r_valid_i) begin
                $display("Error mem_req_o.r_ready: expected 0x%h, got 0x%h",
                         r_valid_i, r_ready_i);
                n_stray++;
            end
        end
        if (exp_valid_i) begin
            err_fifo.push_back(exp_err_i);
            cause_fifo.push_back(exp_cause_i);
            up_fifo.push_back(exp_up_i);
            tag_fifo.push_back(exp_tag_i);
        end
        if (report_i) begin
            $display("Walks checked %0d, mismatched %0d, protocol errors %0d",
                     n_ends, n_bad, n_stray);
        end
        n_ends_o <= n_ends;
        n_bad_o  <= n_bad + n_stray;
    end

endmodule

`default_nettype wire

// File: logic/ptw_top.sv
// Sv39 IOMMU page table walker top, control FSM with pointer, check and context datapath
`timescale 1ns/1ps
`default_nettype none

module ptw_top import ptw_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             init_ptw_i,
    input  walk_req_t        req_i,
    input  logic [PPN_W-1:0] root_ppn_i,
    input  mem_rsp_t         mem_rsp_i,
    output mem_req_t         mem_req_o,
    output logic             ptw_active_o,
    output logic             update_o,
    output iotlb_up_t        up_o,
    output logic             ptw_error_o,
    output cause_e           cause_o
);

    logic            ar_valid;
    logic            r_ready;
    logic            load_root;
    logic            capture;
    logic            step;
    logic            leaf_ok;
    lvl_e            lvl;
    pte_chk_t        chk;
    walk_req_t       ctx;
    pte_t            pte;
    logic [PA_W-1:0] pptr;
    logic [VA_W-1:0] walk_iova;

    assign pte = pte_t'(mem_rsp_i.r_data);

    // Root pointer is built before the context register holds the request
    assign walk_iova = load_root ? req_i.iova : ctx.iova;

    assign mem_req_o.ar_valid = ar_valid;
    assign mem_req_o.ar_addr  = pptr;
    assign mem_req_o.r_ready  = r_ready;

    ptw_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .init_ptw_i   (init_ptw_i),
        .mem_rsp_i    (mem_rsp_i),
        .chk_i        (chk),
        .ar_valid_o   (ar_valid),
        .r_ready_o    (r_ready),
        .load_root_o  (load_root),
        .capture_o    (capture),
        .step_o       (step),
        .leaf_ok_o    (leaf_ok),
        .lvl_o        (lvl),
        .ptw_active_o (ptw_active_o),
        .update_o     (update_o),
        .ptw_error_o  (ptw_error_o),
        .cause_o      (cause_o)
    );

    ptw_addr_gen u_addr_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_root_i (load_root),
        .step_i      (step),
        .lvl_i       (lvl),
        .root_ppn_i  (root_ppn_i),
        .iova_i      (walk_iova),
        .pte_i       (pte),
        .pptr_o      (pptr)
    );

    ptw_pte_check u_pte_check (
        .pte_i      (pte),
        .bus_err_i  (mem_rsp_i.r_err),
        .lvl_i      (lvl),
        .is_store_i (ctx.is_store),
        .chk_o      (chk)
    );

    ptw_walk_ctx u_walk_ctx (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .capture_i (capture),
        .step_i    (step),
        .leaf_ok_i (leaf_ok),
        .req_i     (req_i),
        .pte_i     (pte),
        .lvl_i     (lvl),
        .ctx_o     (ctx),
        .up_o      (up_o)
    );

endmodule

`default_nettype wire

// File: logic/ptw_ctrl.sv
// Walker control FSM with start edge detect, level counter, read strobes and result pulses
`timescale 1ns/1ps
`default_nettype none

module ptw_ctrl import ptw_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     init_ptw_i,
    input  mem_rsp_t mem_rsp_i,
    input  pte_chk_t chk_i,
    output logic     ar_valid_o,
    output logic     r_ready_o,
    output logic     load_root_o,
    output logic     capture_o,
    output logic     step_o,
    output logic     leaf_ok_o,
    output lvl_e     lvl_o,
    output logic     ptw_active_o,
    output logic     update_o,
    output logic     ptw_error_o,
    output cause_e   cause_o
);

    state_e state_q;
    state_e state_n;
    lvl_e   lvl_q;
    lvl_e   lvl_n;
    // Previous init level for rising edge detect
    logic   init_q;
    cause_e cause_q;
    logic   start;
    // Response consumed this cycle
    logic   rsp_take;

    assign start    = (state_q == IDLE) && init_ptw_i && !init_q;
    assign rsp_take = (state_q == PROC_PTE) && mem_rsp_i.r_valid;

    always_comb begin
        state_n = state_q;
        lvl_n   = lvl_q;
        case (state_q)
            IDLE: begin
                // Every walk starts at the root table
                if (start) begin
                    state_n = MEM_ACCESS;
                    lvl_n   = LVL1;
                end
            end
            MEM_ACCESS: begin
                // Hold request until accepted
                if (mem_rsp_i.ar_ready) begin
                    state_n = PROC_PTE;
                end
            end
            PROC_PTE: begin
                if (rsp_take) begin
                    if (chk_i.fault) begin
                        state_n = ERROR;
                    end else if (chk_i.leaf) begin
                        state_n = IDLE;
                    end else begin
                        // Pointer, descend one level
                        state_n = MEM_ACCESS;
                        lvl_n   = (lvl_q == LVL1) ? LVL2 : LVL3;
                    end
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
            init_q  <= 1'b0;
        end else begin
            state_q <= state_n;
            lvl_q   <= lvl_n;
            init_q  <= init_ptw_i;
        end
    end

    // Cause of the faulting entry, reported in ERROR
    always_ff @(posedge clk_i) begin
        if (rsp_take && chk_i.fault) begin
            cause_q <= chk_i.cause;
        end
    end

    assign ar_valid_o   = (state_q == MEM_ACCESS);
    assign r_ready_o    = rsp_take;
    assign load_root_o  = start;
    assign capture_o    = start;
    assign step_o       = rsp_take && !chk_i.fault && !chk_i.leaf;
    assign leaf_ok_o    = rsp_take && !chk_i.fault && chk_i.leaf;
    assign update_o     = leaf_ok_o;
    assign lvl_o        = lvl_q;
    assign ptw_active_o = (state_q != IDLE);
    assign ptw_error_o  = (state_q == ERROR);
    assign cause_o      = (state_q == ERROR) ? cause_q : cause_e'('0);

    // A walk ends in exactly one way
    a_end_excl: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(update_o && ptw_error_o)
    );

    // Read request is not withdrawn before the slave takes it
    a_ar_hold: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ar_valid_o && !mem_rsp_i.ar_ready |=> ar_valid_o
    );

endmodule

`default_nettype wire

// File: logic/ptw_walk_ctx.sv
// Walk context registers holding the captured request and global bit, and the IOTLB fill record
`timescale 1ns/1ps
`default_nettype none

module ptw_walk_ctx import ptw_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      capture_i,
    input  logic      step_i,
    input  logic      leaf_ok_i,
    input  walk_req_t req_i,
    input  pte_t      pte_i,
    input  lvl_e      lvl_i,
    output walk_req_t ctx_o,
    output iotlb_up_t up_o
);

    // Captured request
    walk_req_t ctx_q;
    // Set once a global pointer entry is seen on the current path
    logic      glob_q;
    // Walk in flight, closed by the leaf
    logic      open_q;

    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            ctx_q <= req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            glob_q <= 1'b0;
            open_q <= 1'b0;
        end else begin
            // New walk starts with a clean global flag
            if (capture_i) begin
                glob_q <= 1'b0;
            end else if (step_i && pte_i.g) begin
                glob_q <= 1'b1;
            end
            if (capture_i) begin
                open_q <= 1'b1;
            end else if (leaf_ok_i) begin
                open_q <= 1'b0;
            end
        end
    end

    assign ctx_o = ctx_q;

    // Fill record, valid in the cycle the leaf response is consumed
    always_comb begin
        up_o.vpn       = ctx_q.iova[VA_W-1:12];
        up_o.pscid     = ctx_q.pscid;
        up_o.is_2m     = (lvl_i == LVL2);
        up_o.is_1g     = (lvl_i == LVL1);
        up_o.content   = pte_i;
        // Global from any pointer on the path is inherited by the leaf
        up_o.content.g = pte_i.g | glob_q;
    end

    // A leaf is accepted only inside a walk opened by a capture
    a_leaf_after_capture: assert property (
        @(posedge clk_i) disable iff (!rst_ni) leaf_ok_i |-> open_q
    );

endmodule

`default_nettype wire

// File: logic/ptw_addr_gen.sv
// Page table pointer generator, forms the next entry address from the root or the last pointer
`timescale 1ns/1ps
`default_nettype none

module ptw_addr_gen import ptw_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             load_root_i,
    input  logic             step_i,
    input  lvl_e             lvl_i,
    input  logic [PPN_W-1:0] root_ppn_i,
    input  logic [VA_W-1:0]  iova_i,
    input  pte_t             pte_i,
    output logic [PA_W-1:0]  pptr_o
);

    logic [PA_W-1:0] pptr_q;
    logic [PA_W-1:0] pptr_n;
    // VPN slice indexing the next table
    logic [8:0]      vpn_next;

    // Pointer taken at LVL1 leads to the LVL2 table, VPN[1]
    // Pointer taken at LVL2 leads to the LVL3 table, VPN[0]
    always_comb begin
        if (lvl_i == LVL1) begin
            vpn_next = iova_i[29:21];
        end else begin
            vpn_next = iova_i[20:12];
        end
    end

    always_comb begin
        pptr_n = pptr_q;
        // Root table, indexed by VPN[2]
        if (load_root_i) begin
            pptr_n = {root_ppn_i, iova_i[38:30], 3'b000};
        end else if (step_i) begin
            pptr_n = {pte_i.ppn, vpn_next, 3'b000};
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pptr_q <= '0;
        end else begin
            pptr_q <= pptr_n;
        end
    end

    assign pptr_o = pptr_q;

    // Entries are 64 bit, every read is doubleword aligned
    a_pptr_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_ni) pptr_q[2:0] == 3'b000
    );

endmodule

`default_nettype wire

// File: logic/ptw_pte_check.sv
// Sv39 entry checker, classifies a returned entry as leaf, pointer or fault with its cause
`timescale 1ns/1ps
`default_nettype none

module ptw_pte_check import ptw_pkg::*; (
    input  pte_t     pte_i,
    input  logic     bus_err_i,
    input  lvl_e     lvl_i,
    input  logic     is_store_i,
    output pte_chk_t chk_o
);

    logic is_leaf;
    logic bad_enc;
    logic bad_rsvd;
    logic bad_ptr;
    logic bad_leaf;
    logic misaligned;
    logic pf;

    // R or X set marks a leaf, otherwise a pointer
    assign is_leaf = pte_i.r | pte_i.x;

    always_comb begin
        // Not valid, or writable without read
        bad_enc    = !pte_i.v || (!pte_i.r && pte_i.w);
        // Bits 63:54 must be zero
        bad_rsvd   = |pte_i.reserved;
        // A, D, U reserved on pointers; no pointer allowed at the last level
        bad_ptr    = !is_leaf && (pte_i.a || pte_i.d || pte_i.u || (lvl_i == LVL3));
        // Superpage ppn low bits must be clear
        misaligned = ((lvl_i == LVL1) && (|pte_i.ppn[17:0]))
                  || ((lvl_i == LVL2) && (|pte_i.ppn[8:0]));
        // Access needs A and R, a store also needs D
        bad_leaf   = is_leaf && (misaligned || !pte_i.a || !pte_i.r
                  || (is_store_i && !pte_i.d));
        pf         = bad_enc || bad_rsvd || bad_ptr || bad_leaf;
    end

    always_comb begin
        chk_o.fault = bus_err_i || pf;
        chk_o.leaf  = is_leaf && !chk_o.fault;
        // Bus error takes priority over any page fault
        if (bus_err_i) begin
            chk_o.cause = PT_DATA_CORRUPTION;
        end else if (is_store_i) begin
            chk_o.cause = STORE_PAGE_FAULT;
        end else begin
            chk_o.cause = LOAD_PAGE_FAULT;
        end
    end

endmodule

`default_nettype wire

// File: logic/ptw_pkg.sv
// Sv39 page table walker package with widths, bus records, entry layout and encodings
`default_nettype none

package ptw_pkg;

    // Address and field widths for single-stage Sv39
    localparam int VA_W    = 39;
    localparam int PA_W    = 56;
    localparam int PPN_W   = 44;
    localparam int VPN_W   = 27;
    localparam int PSCID_W = 20;
    localparam int CAUSE_W = 12;

    // Sv39 page table entry, MSB first
    typedef struct packed {
        logic [9:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // Walk level, LVL1 maps 1G, LVL2 maps 2M, LVL3 maps 4K
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } lvl_e;

    // Walker FSM states
    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        ERROR
    } state_e;

    // IOMMU fault cause codes reported by the walker
    typedef enum logic [CAUSE_W-1:0] {
        LOAD_PAGE_FAULT    = 12'd13,
        STORE_PAGE_FAULT   = 12'd15,
        PT_DATA_CORRUPTION = 12'd274
    } cause_e;

    // Read port, request side
    typedef struct packed {
        logic            ar_valid;
        logic [PA_W-1:0] ar_addr;
        logic            r_ready;
    } mem_req_t;

    // Read port, response side
    typedef struct packed {
        logic        ar_ready;
        logic        r_valid;
        logic [63:0] r_data;
        logic        r_err;
    } mem_rsp_t;

    // Translation request from the IOTLB miss path
    typedef struct packed {
        logic [VA_W-1:0]    iova;
        logic [PSCID_W-1:0] pscid;
        logic               is_store;
    } walk_req_t;

    // IOTLB fill record
    typedef struct packed {
        logic [VPN_W-1:0]   vpn;
        logic [PSCID_W-1:0] pscid;
        logic               is_2m;
        logic               is_1g;
        pte_t               content;
    } iotlb_up_t;

    // Entry classification
    typedef struct packed {
        logic   leaf;
        logic   fault;
        cause_e cause;
    } pte_chk_t;

endpackage

`default_nettype wire
